// File: rtl/uart_frame_config.svh
// Clock, baud rate, character width and FIFO depth macros.
`ifndef UART_FRAME_CONFIG_SVH
`define UART_FRAME_CONFIG_SVH

// System clock in Hz.
`define UART_CLK_FREQ   10_000_000

// Line rate giving 10 clocks per bit at the default clock.
`define UART_BAUD_RATE  1_000_000

// Bits per character.
`define UART_DATA_WIDTH 8

// Receive buffer entries as a power of two.
`define FIFO_DEPTH      8

`endif

// File: rtl/uart_frame_pkg.sv
// Stream word and frame header types for the UART frame checker.
`include "uart_frame_config.svh"

package uart_frame_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Stream link
    ////////////////////////////////////////////////////////////////////////////

    // Forward half of a link. Ready travels back on its own wire.
    typedef struct packed {
        logic [`UART_DATA_WIDTH-1:0] data;  // Character.
        logic                        valid; // Data present.
    } byte_stream_t;

    ////////////////////////////////////////////////////////////////////////////
    // Frame header
    ////////////////////////////////////////////////////////////////////////////

    // First byte of every frame. The status byte reuses the layout.
    typedef struct packed {
        logic [3:0] kind; // Frame kind.
        logic [3:0] len;  // Payload bytes from 0 to 15.
    } frame_hdr_t;

endpackage

// File: rtl/uart_rx.sv
// UART receiver with mid start bit check, producing a byte stream.
`timescale 1ns/1ps
`include "uart_frame_config.svh"

module uart_rx (
    input  logic                         clk_i,
    input  logic                         arstn_i,
    input  logic                         uart_rx_i,
    input  logic                         rx_ready_i,
    output uart_frame_pkg::byte_stream_t rx_o
);

    localparam int DIVIDER = `UART_CLK_FREQ / `UART_BAUD_RATE;
    localparam int DW      = `UART_DATA_WIDTH;
    localparam int CNT_W   = $clog2(DIVIDER);
    localparam int BIT_W   = $clog2(DW);

    typedef enum logic [2:0] {S_IDLE, S_START, S_DATA, S_STOP, S_WAIT} rx_state_e;

    rx_state_e        state;
    logic [CNT_W-1:0] baud_cnt;
    logic [BIT_W-1:0] bit_cnt;
    logic [DW-1:0]    shift;
    logic [1:0]       done_q;
    logic [DW-1:0]    out_data;
    logic             out_valid;
    logic             start_mid;
    logic             bit_end;
    logic             last_bit;

    assign start_mid = (state == S_START) && (baud_cnt == CNT_W'(DIVIDER / 2 - 1));
    assign bit_end   = (baud_cnt == CNT_W'(DIVIDER - 1));
    assign last_bit  = (state == S_DATA) && bit_end && (bit_cnt == BIT_W'(DW - 1));

    ////////////////////////////////////////////////////////////////////////////
    // Line FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: begin
                    if (!uart_rx_i) begin
                        state <= S_START;
                    end
                end
                S_START: begin
                    if (start_mid) begin
                        state <= uart_rx_i ? S_IDLE : S_DATA; // High again means a glitch.
                    end
                end
                S_DATA: begin
                    if (last_bit) begin
                        state <= S_STOP;
                    end
                end
                S_STOP: begin
                    if (bit_end) begin
                        state <= S_WAIT;
                    end
                end
                S_WAIT: begin
                    if (uart_rx_i) begin
                        state <= S_IDLE; // Rearm on a high line.
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            baud_cnt <= '0;
            bit_cnt  <= '0;
            done_q   <= '0;
        end else begin
            if (start_mid || bit_end || (state == S_IDLE) || (state == S_WAIT)) begin
                baud_cnt <= '0;
            end else begin
                baud_cnt <= baud_cnt + 1'b1;
            end
            if (last_bit) begin
                bit_cnt <= '0;
            end else if ((state == S_DATA) && bit_end) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
            done_q <= {done_q[0], last_bit}; // Two cycle load delay.
        end
    end

    always_ff @(posedge clk_i) begin
        if ((state == S_DATA) && bit_end) begin
            shift <= {uart_rx_i, shift[DW-1:1]}; // LSB arrives first.
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Output register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            out_valid <= 1'b0;
        end else if (done_q[1]) begin
            out_valid <= 1'b1; // Overwrites an untaken byte.
        end else if (out_valid && rx_ready_i) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (done_q[1]) begin
            out_data <= shift;
        end
    end

    assign rx_o.data  = out_data;
    assign rx_o.valid = out_valid;

endmodule

// File: rtl/byte_fifo.sv
// Synchronous circular buffer for the received byte stream.
`timescale 1ns/1ps
`include "uart_frame_config.svh"

module byte_fifo #(
    parameter int DEPTH = `FIFO_DEPTH
) (
    input  logic                         clk_i,
    input  logic                         arstn_i,
    input  uart_frame_pkg::byte_stream_t wr_i,
    input  logic                         rd_ready_i,
    output logic                         wr_ready_o,
    output uart_frame_pkg::byte_stream_t rd_o
);

    localparam int PTR_W = $clog2(DEPTH);

    logic [`UART_DATA_WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0]            wr_ptr;
    logic [PTR_W-1:0]            rd_ptr;
    logic [PTR_W:0]              count;
    logic                        push;
    logic                        pop;

    assign wr_ready_o = (count != (PTR_W + 1)'(DEPTH));
    assign push       = wr_i.valid && wr_ready_o;
    assign pop        = rd_o.valid && rd_ready_i;

    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1; // Wraps at DEPTH.
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + (PTR_W + 1)'(push) - (PTR_W + 1)'(pop);
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem[wr_ptr] <= wr_i.data;
        end
    end

    assign rd_o.valid = (count != '0);
    assign rd_o.data  = mem[rd_ptr]; // Oldest entry.

endmodule

// File: rtl/frame_checker.sv
// Frame parser that forwards header and payload and swaps the checksum for a status byte.
`timescale 1ns/1ps

module frame_checker (
    input  logic                         clk_i,
    input  logic                         arstn_i,
    input  uart_frame_pkg::byte_stream_t in_i,
    input  logic                         out_ready_i,
    output logic                         in_ready_o,
    output uart_frame_pkg::byte_stream_t out_o
);

    typedef enum logic [1:0] {PH_HDR, PH_PAY, PH_SUM} phase_e;

    phase_e                                         phase;
    logic [3:0]                                     remain;
    logic [3:0]                                     kind_q;
    logic [$bits(uart_frame_pkg::frame_hdr_t)-1:0] xor_q;
    uart_frame_pkg::frame_hdr_t                     hdr;
    uart_frame_pkg::frame_hdr_t                     status;
    logic                                           xfer;

    assign hdr  = uart_frame_pkg::frame_hdr_t'(in_i.data);
    assign xfer = in_i.valid && out_ready_i;

    // Status keeps the kind and flags a checksum mismatch in the low nibble.
    assign status.kind = kind_q;
    assign status.len  = (in_i.data == xor_q) ? 4'h0 : 4'hF;

    ////////////////////////////////////////////////////////////////////////////
    // Phase tracking
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            phase  <= PH_HDR;
            remain <= '0;
        end else if (xfer) begin
            case (phase)
                PH_HDR: begin
                    remain <= hdr.len;
                    phase  <= (hdr.len == 4'd0) ? PH_SUM : PH_PAY; // Empty frame.
                end
                PH_PAY: begin
                    remain <= remain - 1'b1;
                    if (remain == 4'd1) begin
                        phase <= PH_SUM;
                    end
                end
                default: phase <= PH_HDR; // Checksum consumed.
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (xfer && (phase == PH_HDR)) begin
            kind_q <= hdr.kind;
            xor_q  <= in_i.data; // Checksum covers the header.
        end else if (xfer && (phase == PH_PAY)) begin
            xor_q <= xor_q ^ in_i.data;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Pass-through
    ////////////////////////////////////////////////////////////////////////////

    assign in_ready_o  = out_ready_i;
    assign out_o.valid = in_i.valid;
    assign out_o.data  = (phase == PH_SUM) ? status : in_i.data;

endmodule

// File: rtl/uart_tx.sv
// UART transmitter driving the serial line from a byte stream.
`timescale 1ns/1ps
`include "uart_frame_config.svh"

module uart_tx (
    input  logic                         clk_i,
    input  logic                         arstn_i,
    input  uart_frame_pkg::byte_stream_t tx_i,
    output logic                         tx_ready_o,
    output logic                         uart_tx_o
);

    localparam int DIVIDER = `UART_CLK_FREQ / `UART_BAUD_RATE;
    localparam int DW      = `UART_DATA_WIDTH;
    localparam int CNT_W   = $clog2(DIVIDER);
    localparam int BIT_W   = $clog2(DW + 2);

    logic             busy;
    logic [CNT_W-1:0] baud_cnt;
    logic [BIT_W-1:0] bit_cnt;
    logic [DW:0]      shift;
    logic             line_q;
    logic             accept;
    logic             bit_end;

    assign tx_ready_o = !busy;
    assign accept     = tx_i.valid && !busy;
    assign bit_end    = busy && (baud_cnt == CNT_W'(DIVIDER - 1));

    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            busy     <= 1'b0;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            line_q   <= 1'b1; // Line idles high.
        end else if (accept) begin
            busy     <= 1'b1;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            line_q   <= 1'b0; // Start bit.
        end else if (bit_end) begin
            baud_cnt <= '0;
            if (bit_cnt == BIT_W'(DW + 1)) begin
                busy <= 1'b0; // Stop bit done.
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
                line_q  <= shift[0];
            end
        end else if (busy) begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

    // Data LSB first, then the stop bit shifted in from the top.
    always_ff @(posedge clk_i) begin
        if (accept) begin
            shift <= {1'b1, tx_i.data};
        end else if (bit_end) begin
            shift <= {1'b1, shift[DW:1]};
        end
    end

    assign uart_tx_o = line_q;

endmodule

// File: rtl/uart_frame_top.sv
// Top level chaining receiver, FIFO, frame checker and transmitter.
`timescale 1ns/1ps
`include "uart_frame_config.svh"

module uart_frame_top (
    input  logic clk_i,
    input  logic arstn_i,
    input  logic uart_rx_i,
    output logic uart_tx_o
);

    uart_frame_pkg::byte_stream_t rx_s;
    uart_frame_pkg::byte_stream_t fifo_s;
    uart_frame_pkg::byte_stream_t chk_s;
    logic                         rx_ready;
    logic                         fifo_ready;
    logic                         chk_ready;

    uart_rx u_rx (
        .clk_i     (clk_i),
        .arstn_i   (arstn_i),
        .uart_rx_i (uart_rx_i),
        .rx_ready_i(rx_ready),
        .rx_o      (rx_s)
    );

    byte_fifo #(.DEPTH(`FIFO_DEPTH)) u_fifo (
        .clk_i     (clk_i),
        .arstn_i   (arstn_i),
        .wr_i      (rx_s),
        .rd_ready_i(fifo_ready),
        .wr_ready_o(rx_ready),
        .rd_o      (fifo_s)
    );

    frame_checker u_chk (
        .clk_i      (clk_i),
        .arstn_i    (arstn_i),
        .in_i       (fifo_s),
        .out_ready_i(chk_ready),
        .in_ready_o (fifo_ready),
        .out_o      (chk_s)
    );

    uart_tx u_tx (
        .clk_i     (clk_i),
        .arstn_i   (arstn_i),
        .tx_i      (chk_s),
        .tx_ready_o(chk_ready),
        .uart_tx_o (uart_tx_o)
    );

endmodule

// File: sim/tb_uart_frame_top.sv
// Testbench for the UART frame checker with serial driver, monitor, reference model and watchdog.
`timescale 1ns/1ps
`include "uart_frame_config.svh"

module tb_uart_frame_top;

    localparam int BIT_CYCLES = `UART_CLK_FREQ / `UART_BAUD_RATE;
    localparam int DW         = `UART_DATA_WIDTH;
    localparam int MAX_BYTES  = 20 + 20 * 17; // Directed frames plus worst case random.
    localparam int TIMEOUT    = MAX_BYTES * (DW + 2) * BIT_CYCLES * 2 + 2000;

    logic             clk;
    logic             arstn;
    logic             rx_line;
    logic             tx_line;
    logic [DW-1:0]    exp_q[$];
    logic [DW-1:0]    act_q[$];
    integer           seed = 32'he346db0a;
    int               errors;
    int               checked;
    int               exp_total;
    int               rx_count;
    string            test_name;

    uart_frame_top dut0 (
        .clk_i    (clk),
        .arstn_i  (arstn),
        .uart_rx_i(rx_line),
        .uart_tx_o(tx_line)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reference model and checks
    ////////////////////////////////////////////////////////////////////////////

    // Header and payload pass through, checksum becomes kind plus match flag.
    function automatic void expected_frame(input uart_frame_pkg::frame_hdr_t hdr,
                                           input logic [7:0] pay [16],
                                           input logic [7:0] sum);
        logic [7:0]                 acc;
        uart_frame_pkg::frame_hdr_t status;
        int                         i;
        acc = hdr;
        exp_q.push_back(hdr);
        for (i = 0; i < int'(hdr.len); i++) begin
            acc = acc ^ pay[i];
            exp_q.push_back(pay[i]);
        end
        status.kind = hdr.kind;
        status.len  = (acc == sum) ? 4'h0 : 4'hF;
        exp_q.push_back(status);
        exp_total = exp_total + int'(hdr.len) + 2;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            $display("error %s: expected %0h, actual %0h", name, exp, act);
            errors++;
        end
    endtask

    initial begin : compare_proc
        forever begin
            @(negedge clk);
            while ((exp_q.size() > 0) && (act_q.size() > 0)) begin
                check_value(test_name, exp_q.pop_front(), act_q.pop_front());
                checked++;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Serial driver and monitor
    ////////////////////////////////////////////////////////////////////////////

    task automatic send_byte(input logic [DW-1:0] b);
        int i;
        rx_line = 1'b0; // Start bit.
        repeat (BIT_CYCLES) @(negedge clk);
        for (i = 0; i < DW; i++) begin
            rx_line = b[i];
            repeat (BIT_CYCLES) @(negedge clk);
        end
        rx_line = 1'b1;
        repeat (BIT_CYCLES) @(negedge clk);
    endtask

    task automatic send_frame(input logic [3:0] kind, input logic [3:0] len,
                              input logic corrupt);
        logic [7:0]                 pay [16];
        logic [7:0]                 sum;
        uart_frame_pkg::frame_hdr_t hdr;
        int                         i;
        hdr.kind = kind;
        hdr.len  = len;
        sum      = hdr;
        for (i = 0; i < 16; i++) begin
            pay[i] = 8'($random(seed));
        end
        for (i = 0; i < int'(len); i++) begin
            sum = sum ^ pay[i];
        end
        if (corrupt) begin
            sum = sum ^ 8'h5A; // Any nonzero flip breaks the match.
        end
        expected_frame(hdr, pay, sum);
        send_byte(hdr);
        for (i = 0; i < int'(len); i++) begin
            send_byte(pay[i]);
        end
        send_byte(sum);
    endtask

    initial begin : monitor_proc
        logic [DW-1:0] b;
        int            i;
        forever begin
            @(negedge clk);
            if (arstn && (tx_line === 1'b0)) begin
                repeat (BIT_CYCLES / 2 - 1) @(negedge clk); // Middle of start bit.
                for (i = 0; i < DW; i++) begin
                    repeat (BIT_CYCLES) @(negedge clk);
                    b[i] = tx_line;
                end
                repeat (BIT_CYCLES) @(negedge clk);
                if (tx_line !== 1'b1) begin
                    $display("stop bit missing on the transmit line at %0t", $time);
                    errors++;
                end
                act_q.push_back(b);
                rx_count++;
            end
        end
    end

    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (2 * BIT_CYCLES) @(negedge clk);
    endtask

    initial begin : watchdog_proc
        repeat (TIMEOUT) @(posedge clk);
        $display("timeout after %0d cycles, output bytes stopped arriving", TIMEOUT);
        $display("errors: %0d, bytes checked: %0d", errors, checked);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin : main_proc
        int         n;
        logic [8:0] r;
        arstn     = 1'b0;
        rx_line   = 1'b1;
        errors    = 0;
        checked   = 0;
        exp_total = 0;
        rx_count  = 0;
        test_name = "idle_after_reset";
        repeat (8) @(negedge clk);
        arstn = 1'b1;
        repeat (200) begin
            @(negedge clk);
            check_value(test_name, 1, tx_line);
        end

        test_name = "good_checksum";
        send_frame(4'h3, 4'd5, 1'b0);
        wait_drain();

        test_name = "bad_checksum";
        send_frame(4'hA, 4'd3, 1'b1);
        send_frame(4'h6, 4'd4, 1'b0); // Parser must recover.
        wait_drain();

        test_name = "zero_length";
        send_frame(4'hC, 4'd0, 1'b0);
        wait_drain();

        test_name = "random_back_to_back";
        for (n = 0; n < 20; n++) begin
            r = 9'($random(seed));
            send_frame(r[7:4], r[3:0], r[8]);
        end
        wait_drain();

        test_name = "short_glitch";
        rx_line = 1'b0;
        repeat (3) @(negedge clk);
        rx_line = 1'b1;
        repeat (30 * BIT_CYCLES) @(negedge clk);
        check_value("byte_count", exp_total, rx_count);
        if (act_q.size() != 0) begin
            $display("%0d unexpected bytes left on the transmit line", act_q.size());
            errors++;
        end

        $display("errors: %0d, bytes checked: %0d", errors, checked);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: src.f
+incdir+rtl
rtl/uart_frame_pkg.sv
rtl/uart_rx.sv
rtl/byte_fifo.sv
rtl/frame_checker.sv
rtl/uart_tx.sv
rtl/uart_frame_top.sv
sim/tb_uart_frame_top.sv

// File: Bender.yml
package:
  name: uart_frame

export_include_dirs:
  - rtl

sources:
  - rtl/uart_frame_pkg.sv
  - rtl/uart_rx.sv
  - rtl/byte_fifo.sv
  - rtl/frame_checker.sv
  - rtl/uart_tx.sv
  - rtl/uart_frame_top.sv
  - target: simulation
    files:
      - sim/tb_uart_frame_top.sv
